//--- design/mipsPkg.sv
package mipsPkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    localparam logic [XLEN-1:0] RESET_PC = '0;

    // primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_BNE   = 6'h05;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_ANDI  = 6'h0c;
    localparam logic [5:0] OP_ORI   = 6'h0d;
    localparam logic [5:0] OP_LUI   = 6'h0f;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // funct field, opcode 0 only
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_SLTU, ALU_SLL, ALU_LUI
    } aluOpT;

    typedef enum logic [1:0] {FWD_RF, FWD_MEM, FWD_WB} fwdSelT;

    // BR_NONE has to stay zero so a cleared payload is a bubble
    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JUMP} branchKindT;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] instr;
    } fetchToDecT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       rsVal;
        logic [XLEN-1:0]       rtVal;
        logic [XLEN-1:0]       imm;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] dest;
        aluOpT                 aluOp;
        logic                  useImm;
        branchKindT            branchKind;
        logic [XLEN-1:0]       jumpTarget;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
        logic [4:0]            shamt;
    } decToExT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       aluRes;
        logic [XLEN-1:0]       storeData;
        logic [REG_ADDR_W-1:0] dest;
        logic                  regWrite;
        logic                  memRead;
        logic                  memWrite;
    } exToMemT;

    typedef struct packed {
        logic [XLEN-1:0]       pc;
        logic [XLEN-1:0]       result;
        logic [REG_ADDR_W-1:0] dest;
        logic                  regWrite;
    } memToWbT;

endpackage

//--- design/stageReg.sv
`timescale 1ns/1ps

module stageReg #(
    parameter type payloadT = logic
) (
    input  logic    clk,
    input  logic    arstN_i,
    input  logic    stall_i,
    input  logic    flush_i,
    input  logic    valid_i,
    input  payloadT data_i,
    output logic    valid_o,
    output payloadT data_o
);

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            valid_o <= 1'b0;
            data_o  <= '0;
        end else if (!stall_i) begin  // stall keeps the old contents
            if (flush_i) begin
                valid_o <= 1'b0;
                data_o  <= '0;  // bubble, all flags low
            end else begin
                valid_o <= valid_i;
                data_o  <= data_i;
            end
        end
    end

endmodule

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                             clk,
    input  logic                             arstN_i,
    input  logic                             we_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0]   waddr_i,
    input  logic [mipsPkg::XLEN-1:0]         wdata_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0]   raddrA_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0]   raddrB_i,
    output logic [mipsPkg::XLEN-1:0]         rdataA_o,
    output logic [mipsPkg::XLEN-1:0]         rdataB_o
);

    logic [mipsPkg::XLEN-1:0] regs [2**mipsPkg::REG_ADDR_W];

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            for (int i = 0; i < 2**mipsPkg::REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // writeback in the same cycle goes straight to decode
    assign rdataA_o = (raddrA_i == '0) ? '0 :
                      (we_i && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
    assign rdataB_o = (raddrB_i == '0) ? '0 :
                      (we_i && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

//--- design/instDecoder.sv
`timescale 1ns/1ps

module instDecoder (
    input  logic [mipsPkg::XLEN-1:0]       instr_i,
    output mipsPkg::aluOpT                 aluOp_o,
    output logic                           useImm_o,
    output logic [mipsPkg::XLEN-1:0]       imm_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] rs_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] rt_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] dest_o,
    output logic                           regWrite_o,
    output logic                           memRead_o,
    output logic                           memWrite_o,
    output mipsPkg::branchKindT            branchKind_o,
    output logic [4:0]                     shamt_o
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic       zeroExt;  // andi and ori only

    assign opcode  = instr_i[31:26];
    assign funct   = instr_i[5:0];
    assign rs_o    = instr_i[25:21];
    assign rt_o    = instr_i[20:16];
    assign shamt_o = instr_i[10:6];

    always_comb begin
        aluOp_o      = mipsPkg::ALU_ADD;
        useImm_o     = 1'b0;
        dest_o       = instr_i[20:16];
        regWrite_o   = 1'b0;
        memRead_o    = 1'b0;
        memWrite_o   = 1'b0;
        branchKind_o = mipsPkg::BR_NONE;
        zeroExt      = 1'b0;
        case (opcode)
            mipsPkg::OP_RTYPE: begin
                dest_o     = instr_i[15:11];  // rd
                regWrite_o = 1'b1;
                case (funct)
                    mipsPkg::FN_ADDU: aluOp_o = mipsPkg::ALU_ADD;
                    mipsPkg::FN_SUBU: aluOp_o = mipsPkg::ALU_SUB;
                    mipsPkg::FN_AND:  aluOp_o = mipsPkg::ALU_AND;
                    mipsPkg::FN_OR:   aluOp_o = mipsPkg::ALU_OR;
                    mipsPkg::FN_XOR:  aluOp_o = mipsPkg::ALU_XOR;
                    mipsPkg::FN_SLT:  aluOp_o = mipsPkg::ALU_SLT;
                    mipsPkg::FN_SLTU: aluOp_o = mipsPkg::ALU_SLTU;
                    mipsPkg::FN_SLL:  aluOp_o = mipsPkg::ALU_SLL;
                    default:          regWrite_o = 1'b0;  // unknown funct
                endcase
            end
            mipsPkg::OP_ADDIU: begin
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
            end
            mipsPkg::OP_ANDI: begin
                aluOp_o    = mipsPkg::ALU_AND;
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
                zeroExt    = 1'b1;
            end
            mipsPkg::OP_ORI: begin
                aluOp_o    = mipsPkg::ALU_OR;
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
                zeroExt    = 1'b1;
            end
            mipsPkg::OP_LUI: begin
                aluOp_o    = mipsPkg::ALU_LUI;
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
            end
            mipsPkg::OP_LW: begin
                useImm_o   = 1'b1;
                regWrite_o = 1'b1;
                memRead_o  = 1'b1;
            end
            mipsPkg::OP_SW: begin
                useImm_o   = 1'b1;
                memWrite_o = 1'b1;
            end
            mipsPkg::OP_BEQ: begin
                aluOp_o      = mipsPkg::ALU_SUB;
                branchKind_o = mipsPkg::BR_BEQ;
            end
            mipsPkg::OP_BNE: begin
                aluOp_o      = mipsPkg::ALU_SUB;
                branchKind_o = mipsPkg::BR_BNE;
            end
            mipsPkg::OP_J:  branchKind_o = mipsPkg::BR_JUMP;
            default: ;  // anything else is a no-op
        endcase
    end

    assign imm_o = zeroExt ? {16'b0, instr_i[15:0]} : {{16{instr_i[15]}}, instr_i[15:0]};

endmodule

//--- design/alu.sv
`timescale 1ns/1ps

module alu (
    input  mipsPkg::aluOpT           op_i,
    input  logic [mipsPkg::XLEN-1:0] a_i,
    input  logic [mipsPkg::XLEN-1:0] b_i,
    input  logic [4:0]               shamt_i,
    output logic [mipsPkg::XLEN-1:0] result_o,
    output logic                     equal_o
);

    logic lessSigned;
    logic lessUnsigned;

    assign lessSigned   = $signed(a_i) < $signed(b_i);
    assign lessUnsigned = a_i < b_i;

    always_comb begin
        case (op_i)
            mipsPkg::ALU_ADD:  result_o = a_i + b_i;
            mipsPkg::ALU_SUB:  result_o = a_i - b_i;
            mipsPkg::ALU_AND:  result_o = a_i & b_i;
            mipsPkg::ALU_OR:   result_o = a_i | b_i;
            mipsPkg::ALU_XOR:  result_o = a_i ^ b_i;
            mipsPkg::ALU_SLT:  result_o = {{(mipsPkg::XLEN-1){1'b0}}, lessSigned};
            mipsPkg::ALU_SLTU: result_o = {{(mipsPkg::XLEN-1){1'b0}}, lessUnsigned};
            mipsPkg::ALU_SLL:  result_o = b_i << shamt_i;  // sll shifts rt
            mipsPkg::ALU_LUI:  result_o = {b_i[15:0], 16'b0};
            default:           result_o = '0;
        endcase
    end

    // rs against rt for beq and bne
    assign equal_o = (a_i == b_i);

endmodule

//--- design/hazardUnit.sv
`timescale 1ns/1ps

module hazardUnit (
    input  logic [mipsPkg::REG_ADDR_W-1:0] rsD_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtD_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rsE_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] rtE_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] destE_i,
    input  logic                           memReadE_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] destM_i,
    input  logic                           regWriteM_i,
    input  logic [mipsPkg::REG_ADDR_W-1:0] destW_i,
    input  logic                           regWriteW_i,
    input  logic                           redirectE_i,
    output mipsPkg::fwdSelT                fwdA_o,
    output mipsPkg::fwdSelT                fwdB_o,
    output logic                           stallFD_o,
    output logic                           flushDE_o,
    output logic                           flushFD_o
);

    logic loadUse;

    // memory stage is younger, so it is checked first
    function automatic mipsPkg::fwdSelT pickSrc(
        input logic [mipsPkg::REG_ADDR_W-1:0] src,
        input logic [mipsPkg::REG_ADDR_W-1:0] destM,
        input logic                           writeM,
        input logic [mipsPkg::REG_ADDR_W-1:0] destW,
        input logic                           writeW
    );
        if (src == '0) begin
            return mipsPkg::FWD_RF;
        end
        if (writeM && destM == src) begin
            return mipsPkg::FWD_MEM;
        end
        if (writeW && destW == src) begin
            return mipsPkg::FWD_WB;
        end
        return mipsPkg::FWD_RF;
    endfunction

    assign fwdA_o = pickSrc(rsE_i, destM_i, regWriteM_i, destW_i, regWriteW_i);
    assign fwdB_o = pickSrc(rtE_i, destM_i, regWriteM_i, destW_i, regWriteW_i);

    assign loadUse = memReadE_i && (destE_i != '0) &&
                     (destE_i == rsD_i || destE_i == rtD_i);

    // a redirect squashes the consumer anyway
    assign stallFD_o = loadUse && !redirectE_i;
    assign flushFD_o = redirectE_i;
    assign flushDE_o = redirectE_i || loadUse;  // bubble into execute

endmodule

//--- design/mipsCore.sv
`timescale 1ns/1ps

module mipsCore (
    input  logic                           clk,
    input  logic                           arstN_i,
    output logic [mipsPkg::XLEN-1:0]       instAddr_o,
    input  logic [mipsPkg::XLEN-1:0]       instRdata_i,
    output logic                           memEn_o,
    output logic                           memWe_o,
    output logic [mipsPkg::XLEN-1:0]       memAddr_o,
    output logic [mipsPkg::XLEN-1:0]       memWdata_o,
    input  logic [mipsPkg::XLEN-1:0]       memRdata_i,
    output logic                           dbgWbValid_o,
    output logic [mipsPkg::XLEN-1:0]       dbgWbPc_o,
    output logic                           dbgWbWen_o,
    output logic [mipsPkg::REG_ADDR_W-1:0] dbgWbNum_o,
    output logic [mipsPkg::XLEN-1:0]       dbgWbData_o
);

    logic [mipsPkg::XLEN-1:0] pcF, pcNextF;
    mipsPkg::fetchToDecT      fetchF, fetchD;
    logic                     validD, validE, validM, validW;

    mipsPkg::aluOpT                 aluOpD;
    mipsPkg::branchKindT            branchKindD;
    logic                           useImmD, regWriteD, memReadD, memWriteD;
    logic [mipsPkg::XLEN-1:0]       immD, rsValD, rtValD;
    logic [mipsPkg::REG_ADDR_W-1:0] rsD, rtD, destD;
    logic [4:0]                     shamtD;
    mipsPkg::decToExT               decD, exE;

    mipsPkg::fwdSelT          fwdA, fwdB;
    logic [mipsPkg::XLEN-1:0] srcAE, rtFwdE, srcBE, aluResE, redirectPcE;
    logic                     equalE, takenE, redirectE;
    mipsPkg::exToMemT         exOutE, memM;

    logic [mipsPkg::XLEN-1:0] resultM;
    mipsPkg::memToWbT         memOutM, wbW;
    logic                     regWriteM, regWriteW;
    logic                     stallFD, flushFD, flushDE;

    function automatic logic [mipsPkg::XLEN-1:0] fwdMux(
        input mipsPkg::fwdSelT          sel,
        input logic [mipsPkg::XLEN-1:0] rfVal,
        input logic [mipsPkg::XLEN-1:0] memVal,
        input logic [mipsPkg::XLEN-1:0] wbVal
    );
        case (sel)
            mipsPkg::FWD_MEM: return memVal;
            mipsPkg::FWD_WB:  return wbVal;
            default:          return rfVal;
        endcase
    endfunction

    // fetch
    assign pcNextF    = redirectE ? redirectPcE : pcF + 32'd4;
    assign instAddr_o = pcF;
    assign fetchF     = '{pc: pcF, instr: instRdata_i};

    always_ff @(posedge clk or negedge arstN_i) begin
        if (!arstN_i) begin
            pcF <= mipsPkg::RESET_PC;
        end else if (!stallFD) begin
            pcF <= pcNextF;
        end
    end

    stageReg #(.payloadT(mipsPkg::fetchToDecT)) fdReg (
        .clk(clk), .arstN_i(arstN_i), .stall_i(stallFD), .flush_i(flushFD),
        .valid_i(1'b1), .data_i(fetchF), .valid_o(validD), .data_o(fetchD)
    );

    // decode
    instDecoder decoder0 (
        .instr_i(fetchD.instr), .aluOp_o(aluOpD), .useImm_o(useImmD), .imm_o(immD),
        .rs_o(rsD), .rt_o(rtD), .dest_o(destD), .regWrite_o(regWriteD),
        .memRead_o(memReadD), .memWrite_o(memWriteD), .branchKind_o(branchKindD),
        .shamt_o(shamtD)
    );

    regFile rf0 (
        .clk(clk), .arstN_i(arstN_i), .we_i(regWriteW), .waddr_i(wbW.dest),
        .wdata_i(wbW.result), .raddrA_i(rsD), .raddrB_i(rtD),
        .rdataA_o(rsValD), .rdataB_o(rtValD)
    );

    always_comb begin
        decD.pc         = fetchD.pc;
        decD.rsVal      = rsValD;
        decD.rtVal      = rtValD;
        decD.imm        = immD;
        decD.rs         = rsD;
        decD.rt         = rtD;
        decD.dest       = destD;
        decD.aluOp      = aluOpD;
        decD.useImm     = useImmD;
        decD.branchKind = branchKindD;
        decD.regWrite   = regWriteD;
        decD.memRead    = memReadD;
        decD.memWrite   = memWriteD;
        decD.shamt      = shamtD;
        decD.jumpTarget = {fetchD.pc[31:28] , fetchD.instr[25:0], 2'b00};  // j region of pc
    end

    stageReg #(.payloadT(mipsPkg::decToExT)) deReg (
        .clk(clk), .arstN_i(arstN_i), .stall_i(1'b0), .flush_i(flushDE),
        .valid_i(validD), .data_i(decD), .valid_o(validE), .data_o(exE)
    );

    // execute
    assign srcAE  = fwdMux(fwdA, exE.rsVal, resultM, wbW.result);
    assign rtFwdE = fwdMux(fwdB, exE.rtVal, resultM, wbW.result);
    assign srcBE  = exE.useImm ? exE.imm : rtFwdE;

    alu alu0 (
        .op_i(exE.aluOp), .a_i(srcAE), .b_i(srcBE), .shamt_i(exE.shamt),
        .result_o(aluResE), .equal_o(equalE)
    );

    always_comb begin
        case (exE.branchKind)
            mipsPkg::BR_BEQ:  takenE = equalE;
            mipsPkg::BR_BNE:  takenE = !equalE;
            mipsPkg::BR_JUMP: takenE = 1'b1;
            default:          takenE = 1'b0;
        endcase
    end

    assign redirectE   = validE && takenE;
    assign redirectPcE = (exE.branchKind == mipsPkg::BR_JUMP) ? exE.jumpTarget :
                         exE.pc + 32'd4 + {exE.imm[29:0], 2'b00};

    assign exOutE = '{pc: exE.pc, aluRes: aluResE, storeData: rtFwdE, dest: exE.dest,
                      regWrite: exE.regWrite, memRead: exE.memRead, memWrite: exE.memWrite};

    stageReg #(.payloadT(mipsPkg::exToMemT)) emReg (
        .clk(clk), .arstN_i(arstN_i), .stall_i(1'b0), .flush_i(1'b0),
        .valid_i(validE), .data_i(exOutE), .valid_o(validM), .data_o(memM)
    );

    // memory, word accesses only
    assign memEn_o    = validM && (memM.memRead || memM.memWrite);
    assign memWe_o    = validM && memM.memWrite;
    assign memAddr_o  = memM.aluRes;
    assign memWdata_o = memM.storeData;
    assign resultM    = memM.memRead ? memRdata_i : memM.aluRes;
    assign regWriteM  = validM && memM.regWrite;

    assign memOutM = '{pc: memM.pc, result: resultM, dest: memM.dest, regWrite: memM.regWrite};

    stageReg #(.payloadT(mipsPkg::memToWbT)) mwReg (
        .clk(clk), .arstN_i(arstN_i), .stall_i(1'b0), .flush_i(1'b0),
        .valid_i(validM), .data_i(memOutM), .valid_o(validW), .data_o(wbW)
    );

    // writeback and trace
    assign regWriteW    = validW && wbW.regWrite;
    assign dbgWbValid_o = validW;
    assign dbgWbPc_o    = wbW.pc;
    assign dbgWbWen_o   = regWriteW && (wbW.dest != '0);  // r0 never shows as written
    assign dbgWbNum_o   = wbW.dest;
    assign dbgWbData_o  = wbW.result;

    hazardUnit hazard0 (
        .rsD_i(rsD), .rtD_i(rtD), .rsE_i(exE.rs), .rtE_i(exE.rt),
        .destE_i(exE.dest), .memReadE_i(exE.memRead),
        .destM_i(memM.dest), .regWriteM_i(regWriteM),
        .destW_i(wbW.dest), .regWriteW_i(regWriteW),
        .redirectE_i(redirectE), .fwdA_o(fwdA), .fwdB_o(fwdB),
        .stallFD_o(stallFD), .flushDE_o(flushDE), .flushFD_o(flushFD)
    );

endmodule

//--- include/tbIsaModel.svh
`ifndef TB_ISA_MODEL_SVH
`define TB_ISA_MODEL_SVH

localparam logic [4:0] BASE_REG = 5'd28;  // only lw and sw use it

logic [31:0] lfsrState = 32'h7360d388;

// galois lfsr, one step per bit taken
function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
        v = {v[30:0], lfsrState[0]};
        lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ 32'h80200003) : (lfsrState >> 1);
    end
    return v;
endfunction

function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                     input logic [4:0] rd, input logic [4:0] sh,
                                     input logic [5:0] fn);
    return {mipsPkg::OP_RTYPE, rs, rt, rd, sh, fn};
endfunction

function automatic logic [31:0] encI(input logic [5:0] op, input logic [4:0] rs,
                                     input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
endfunction

// small pool keeps producers and consumers close together
function automatic logic [4:0] pickReg(input int mode);
    if (randBits(4) == 32'd0) begin
        return 5'd0;
    end
    if (mode == 4 && randBits(1) == 32'd1) begin
        return 5'd0;
    end
    return 5'(32'd1 + randBits(3));
endfunction

function automatic logic [31:0] aluInstr(input int mode);
    logic [4:0]  rs;
    logic [4:0]  rt;
    logic [4:0]  rd;
    logic [15:0] imm;
    rs  = pickReg(mode);
    rt  = pickReg(mode);
    rd  = pickReg(mode);
    imm = 16'(randBits(16));
    case (randBits(4) % 32'd12)
        0: return encR(rs, rt, rd, 5'd0, mipsPkg::FN_ADDU);
        1: return encR(rs, rt, rd, 5'd0, mipsPkg::FN_SUBU);
        2: return encR(rs, rt, rd, 5'd0, mipsPkg::FN_AND);
        3: return encR(rs, rt, rd, 5'd0, mipsPkg::FN_OR);
        4: return encR(rs, rt, rd, 5'd0, mipsPkg::FN_XOR);
        5: return encR(rs, rt, rd, 5'd0, mipsPkg::FN_SLT);
        6: return encR(rs, rt, rd, 5'd0, mipsPkg::FN_SLTU);
        7: return encR(5'd0, rt, rd, imm[4:0], mipsPkg::FN_SLL);
        8: return encI(mipsPkg::OP_ADDIU, rs, rd, imm);
        9: return encI(mipsPkg::OP_ANDI, rs, rd, imm);
        10: return encI(mipsPkg::OP_ORI, rs, rd, imm);
        default: return encI(mipsPkg::OP_LUI, 5'd0, rd, imm);
    endcase
endfunction

function automatic logic [31:0] memInstr(input logic isLoad, input logic [4:0] rt);
    logic [15:0] off;
    off = {10'b0, 4'(randBits(4)), 2'b00};  // 0 to 60 bytes
    return encI(isLoad ? mipsPkg::OP_LW : mipsPkg::OP_SW, BASE_REG, rt, off);
endfunction

// targets are always forward and never past the last word
function automatic logic [31:0] branchInstr(input int i, input int last);
    int         skip;
    logic [4:0] ra;
    logic [4:0] rb;
    skip = int'(randBits(3));
    ra   = pickReg(5);
    rb   = pickReg(5);
    if (skip > last - i - 1) begin
        skip = last - i - 1;
    end
    case (randBits(2))
        0: return {mipsPkg::OP_J, 26'(i + 1 + skip)};
        1: return encI(mipsPkg::OP_BEQ, ra, rb, 16'(skip));
        2: return encI(mipsPkg::OP_BNE, ra, rb, 16'(skip));
        default: return encI(mipsPkg::OP_BEQ, ra, ra, 16'(skip));  // always taken
    endcase
endfunction

task automatic buildProgram(input int mode, input int nInstr);
    int         last;
    int         i;
    logic [4:0] r;
    logic [2:0] kind;
    last = nInstr - 1;
    for (int a = 0; a < IMEM_WORDS; a++) begin
        imem[a] = '0;  // sll r0 acts as a nop
    end
    imem[0] = encI(mipsPkg::OP_LUI, 5'd0, BASE_REG, 16'h1000);
    imem[1] = encI(mipsPkg::OP_ORI, BASE_REG, BASE_REG, 16'h0400);
    i = 2;
    while (i < last) begin
        kind = 3'(randBits(3));
        if ((mode == 2 && kind < 3'd5) || (mode == 5 && kind < 3'd2)) begin
            r = pickReg(mode);
            imem[i] = memInstr(kind[0], r);
            if (mode == 2 && kind[0] && i + 1 < last) begin
                i++;  // consumer right behind the load
                imem[i] = encR(r, pickReg(mode), pickReg(mode), 5'd0, mipsPkg::FN_ADDU);
            end
        end else if ((mode == 3 && kind < 3'd3) || (mode == 5 && kind == 3'd2)) begin
            imem[i] = branchInstr(i, last);
        end else begin
            imem[i] = aluInstr(mode);
        end
        i++;
    end
    imem[last] = {mipsPkg::OP_J, 26'(last)};  // spin at the end
endtask

`endif

//--- tests/tbMipsCore.sv
`timescale 1ns/1ps

module tbMipsCore;

    localparam int IMEM_WORDS = 256;
    localparam int DMEM_WORDS = 256;

    logic        clk;
    logic        arstN;
    logic [31:0] instAddr;
    logic [31:0] instRdata;
    logic        memEn;
    logic        memWe;
    logic [31:0] memAddr;
    logic [31:0] memWdata;
    logic [31:0] memRdata;
    logic        dbgWbValid;
    logic        dbgWbWen;
    logic [31:0] dbgWbPc;
    logic [4:0]  dbgWbNum;
    logic [31:0] dbgWbData;

    logic [31:0] imem    [IMEM_WORDS];
    logic [31:0] dmem    [DMEM_WORDS];
    logic [31:0] dmemRef [DMEM_WORDS];

    // expected commit list
    logic [31:0] expPc   [$];
    logic        expWen  [$];
    logic [4:0]  expNum  [$];
    logic [31:0] expData [$];

    string testName;
    int    expTotal;
    int    nextIdx;
    bit    firstSeen;
    int    testErrors;
    int    errorCount;
    int    passCount;
    int    failCount;
    int    cycleCount;
    int    deadline;

    `include "tbIsaModel.svh"

    mipsCore dut0 (
        .clk(clk), .arstN_i(arstN),
        .instAddr_o(instAddr), .instRdata_i(instRdata),
        .memEn_o(memEn), .memWe_o(memWe), .memAddr_o(memAddr),
        .memWdata_o(memWdata), .memRdata_i(memRdata),
        .dbgWbValid_o(dbgWbValid), .dbgWbPc_o(dbgWbPc), .dbgWbWen_o(dbgWbWen),
        .dbgWbNum_o(dbgWbNum), .dbgWbData_o(dbgWbData)
    );

    assign instRdata = imem[instAddr[9:2]];
    assign memRdata  = dmem[memAddr[9:2]];  // word index only

    always #2 clk = ~clk;

    always @(posedge clk) begin
        if (memEn && memWe) begin
            dmem[memAddr[9:2]] <= memWdata;
        end
    end

    // multiplier mixes every address bit into the word
    function automatic logic [31:0] fillWord(input int idx);
        return (32'(idx) * 32'h9e3779b1) ^ 32'h5ac30f96;
    endfunction

    task automatic loadDataMems();
        for (int a = 0; a < DMEM_WORDS; a++) begin
            dmem[a]    <= fillWord(a);
            dmemRef[a]  = fillWord(a);
        end
    endtask

    // sequential ISA execution of imem, fills the expected commit list
    function automatic int runReference();
        logic [31:0] regs [32];
        logic [31:0] pc, ins, a, b, se, ze, res, nextPc, addr;
        logic [4:0]  dest;
        logic        wr;
        for (int r = 0; r < 32; r++) begin
            regs[r] = '0;
        end
        expPc.delete();
        expWen.delete();
        expNum.delete();
        expData.delete();
        pc = mipsPkg::RESET_PC;
        for (int step = 0; step < IMEM_WORDS; step++) begin
            ins    = imem[pc[9:2]];
            a      = regs[ins[25:21]];
            b      = regs[ins[20:16]];
            se     = {{16{ins[15]}}, ins[15:0]};
            ze     = {16'b0, ins[15:0]};
            addr   = a + se;
            nextPc = pc + 32'd4;
            dest   = ins[20:16];
            wr     = 1'b1;
            res    = '0;
            case (ins[31:26])
                mipsPkg::OP_RTYPE: begin
                    dest = ins[15:11];
                    case (ins[5:0])
                        mipsPkg::FN_ADDU: res = a + b;
                        mipsPkg::FN_SUBU: res = a - b;
                        mipsPkg::FN_AND:  res = a & b;
                        mipsPkg::FN_OR:   res = a | b;
                        mipsPkg::FN_XOR:  res = a ^ b;
                        mipsPkg::FN_SLT:  res = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                        mipsPkg::FN_SLTU: res = (a < b) ? 32'd1 : 32'd0;
                        mipsPkg::FN_SLL:  res = b << ins[10:6];
                        default:          wr = 1'b0;
                    endcase
                end
                mipsPkg::OP_ADDIU: res = a + se;
                mipsPkg::OP_ANDI:  res = a & ze;
                mipsPkg::OP_ORI:   res = a | ze;
                mipsPkg::OP_LUI:   res = {ins[15:0], 16'b0};
                mipsPkg::OP_LW:    res = dmemRef[addr[9:2]];
                mipsPkg::OP_SW: begin
                    wr = 1'b0;
                    dmemRef[addr[9:2]] = b;
                end
                mipsPkg::OP_BEQ: begin
                    wr = 1'b0;
                    if (a == b) begin
                        nextPc = pc + 32'd4 + {se[29:0], 2'b00};
                    end
                end
                mipsPkg::OP_BNE: begin
                    wr = 1'b0;
                    if (a != b) begin
                        nextPc = pc + 32'd4 + {se[29:0], 2'b00};
                    end
                end
                mipsPkg::OP_J: begin
                    wr = 1'b0;
                    nextPc = {nextPc[31:28], ins[25:0], 2'b00};
                end
                default: wr = 1'b0;
            endcase
            if (wr && dest != 5'd0) begin
                regs[dest] = res;
            end
            expPc.push_back(pc);
            expWen.push_back(wr && dest != 5'd0);
            expNum.push_back(dest);
            expData.push_back(res);
            if (ins[31:26] == mipsPkg::OP_J && nextPc == pc) begin
                break;  // the closing self jump
            end
            pc = nextPc;
        end
        return expPc.size();
    endfunction

    task automatic flagMismatch(input string what, input logic [31:0] expVal,
                                input logic [31:0] actVal);
        testErrors++;
        $display("[FAIL] %s %s: expected %h actual %h", testName, what, expVal, actVal);
    endtask

    task automatic flagProblem(input string msg);
        testErrors++;
        $display("%s: %s", testName, msg);
    endtask

    task automatic compareCommit(input int k);
        string tag;
        tag = $sformatf("commit %0d", k);
        if (dbgWbPc !== expPc[k]) begin
            flagMismatch({tag, " pc"}, expPc[k], dbgWbPc);
        end
        if (dbgWbWen !== expWen[k]) begin
            flagMismatch({tag, " wen"}, 32'(expWen[k]), 32'(dbgWbWen));
        end
        if (expWen[k] && dbgWbNum !== expNum[k]) begin
            flagMismatch({tag, " reg"}, 32'(expNum[k]), 32'(dbgWbNum));
        end
        if (expWen[k] && dbgWbData !== expData[k]) begin
            flagMismatch({tag, " data"}, expData[k], dbgWbData);
        end
    endtask

    // sample in the middle of the low phase
    always @(negedge clk) begin
        #1;
        if (!arstN) begin
            if (dbgWbValid || dbgWbWen || memEn || memWe) begin
                flagProblem("commit or data strobe seen while reset is asserted");
            end
        end else begin
            if (!firstSeen && memEn) begin
                flagProblem("data port enabled before the first commit");
            end
            if (dbgWbValid) begin
                if (!firstSeen && dbgWbPc !== mipsPkg::RESET_PC) begin
                    flagMismatch("first commit pc", mipsPkg::RESET_PC, dbgWbPc);
                end
                firstSeen = 1'b1;
                if (nextIdx < expTotal) begin  // repeats of the final j are ignored
                    compareCommit(nextIdx);
                    nextIdx++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > deadline) begin
            $display("watchdog: %s still running after %0d cycles", testName, deadline);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic runTest(input string name, input int mode, input int nInstr);
        @(negedge clk);
        arstN      = 1'b0;
        testName   = name;
        testErrors = 0;
        nextIdx    = 0;
        firstSeen  = 1'b0;
        cycleCount = 0;
        deadline   = 20 * nInstr + 100;
        buildProgram(mode, nInstr);
        loadDataMems();
        expTotal = runReference();
        repeat (3) @(negedge clk);
        arstN = 1'b1;
        wait (nextIdx == expTotal);
        @(negedge clk);
        for (int a = 0; a < DMEM_WORDS; a++) begin
            if (dmem[a] !== dmemRef[a]) begin
                flagMismatch($sformatf("data word %0d", a), dmemRef[a], dmem[a]);
            end
        end
        errorCount += testErrors;
        if (testErrors == 0) begin
            passCount++;
            $display("%s passed, %0d commits", name, expTotal);
        end else begin
            failCount++;
            $display("%s failed, %0d errors", name, testErrors);
        end
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        expTotal   = 0;
        nextIdx    = 0;
        firstSeen  = 1'b0;
        testErrors = 0;
        errorCount = 0;
        passCount  = 0;
        failCount  = 0;
        cycleCount = 0;
        deadline   = 100;
        testName   = "startup";
        for (int a = 0; a < IMEM_WORDS; a++) begin
            imem[a] = '0;
        end
        loadDataMems();
        runTest("reset", 0, 8);
        runTest("aluChain", 1, 40);
        runTest("loadStore", 2, 40);
        runTest("branchJump", 3, 40);
        runTest("regZero", 4, 30);
        for (int t = 0; t < 4; t++) begin
            runTest($sformatf("random%0d", t), 5, 64);
        end
        $display("%0d tests: %0d passed, %0d failed, %0d errors",
                 passCount + failCount, passCount, failCount, errorCount);
        if (failCount == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- filelist.f
+incdir+include
design/mipsPkg.sv
design/stageReg.sv
design/regFile.sv
design/instDecoder.sv
design/alu.sv
design/hazardUnit.sv
design/mipsCore.sv
tests/tbMipsCore.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= tbMipsCore
FILELIST   ?= filelist.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --lint-only -Wall --timing
SIM_FLAGS  ?= --binary --timing -j 0
PASS_TEXT  ?= Test OK

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
